//--- Bender.yml
package:
  name: cap_buffer

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cap_pkg.sv
      - fifo/fifo.sv
      - hw/frame_packer.sv
      - hw/error_log.sv
      - hw/cap_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/tb_cap_top.sv

//--- common/cap_defs.svh
// ----------------------------------------------------------
// capture buffer sizing macros
// fifo depth, level thresholds, payload and counter widths
// ----------------------------------------------------------
`ifndef CAP_DEFS_SVH
`define CAP_DEFS_SVH

// fifo address width, 16 slots and 15 usable entries
`define CAP_DEPTH_LOG2 4

// level thresholds on the fill count
`define CAP_ALMOST_FULL 10  // almost_full at or above this
`define CAP_ALMOST_EMPTY 4  // almost_empty at or below this

// payload widths
`define CAP_SAMPLE_W 16
`define CAP_TAG_W 8

`define CAP_ERR_CNT_W 8  // per-channel reject counter

`endif

//--- common/cap_pkg.sv
// ----------------------------------------------------------
// capture buffer types
// sample and tag words, packed frame, fifo status, err count
// ----------------------------------------------------------
`include "cap_defs.svh"

package cap_pkg;

  // raw payload words
  typedef logic [`CAP_SAMPLE_W-1:0] sample_t;
  typedef logic [`CAP_TAG_W-1:0] tag_t;

  // one packed output frame, tag in the upper byte
  typedef struct packed {
    tag_t    tag;     // bits 23:16
    sample_t sample;  // bits 15:0
  } frame_t;

  // level flags of one fifo
  typedef struct packed {
    logic empty;         // fill count is zero
    logic almost_empty;  // count at or below low mark
    logic almost_full;   // count at or above high mark
    logic full;          // one slot left unused
  } fifo_status_t;

  // saturating count of rejected pushes
  typedef logic [`CAP_ERR_CNT_W-1:0] err_count_t;

endpackage : cap_pkg

//--- fifo/fifo.sv
// ----------------------------------------------------------
// synchronous show-ahead fifo, payload given as a type
// level flags from the pointer difference, push-on-full
// without a pop is dropped and flagged on error
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "cap_defs.svh"

module fifo
  import cap_pkg::*;
#(
  parameter type payload_t = sample_t,
  parameter int DEPTH_LOG2 = `CAP_DEPTH_LOG2
) (
  input  logic         clk,
  input  logic         reset_n,
  input  payload_t     data_in,
  input  logic         push,
  input  logic         pop,
  output payload_t     data_out,
  output fifo_status_t status,
  output logic         error
);

  localparam int unsigned SLOTS = 2 ** DEPTH_LOG2;
  localparam int unsigned FULL_COUNT = SLOTS - 1;  // one slot always kept free
  localparam int unsigned AF_COUNT = `CAP_ALMOST_FULL;
  localparam int unsigned AE_COUNT = `CAP_ALMOST_EMPTY;

  payload_t mem [SLOTS];  // storage array

  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic [DEPTH_LOG2-1:0] count;  // entries held

  logic full;
  logic empty;
  logic wr_en;
  logic rd_en;

  // pointer difference wraps on its own at DEPTH_LOG2 bits
  assign count = wr_ptr - rd_ptr;

  assign empty = (count == '0);
  assign full  = (count == DEPTH_LOG2'(FULL_COUNT));

  // write when room, or when full but a pop frees a slot this cycle
  assign wr_en = push && (!full || pop);
  assign rd_en = pop && !empty;  // read side only moves with data present

  // reject: push into full with no pop
  assign error = push && full && !pop;

  // flags straight from the fill count
  assign status.empty        = empty;
  assign status.almost_empty = (count <= DEPTH_LOG2'(AE_COUNT));
  assign status.almost_full  = (count >= DEPTH_LOG2'(AF_COUNT));
  assign status.full         = full;

  // head word is shown ahead of the pop
  assign data_out = mem[rd_ptr];

  // pointers
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (wr_en)
      begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at SLOTS
      end
      if (rd_en)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // storage write, a dropped push leaves the array alone
  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      mem[wr_ptr] <= data_in;
    end
  end

endmodule : fifo

//--- hw/cap_top.sv
// ----------------------------------------------------------
// capture buffer top
// sample and tag fifos, frame packer and error log
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "cap_defs.svh"

module cap_top
  import cap_pkg::*;
(
  input  logic         clk,
  input  logic         reset_n,
  input  sample_t      sample_in,
  input  logic         sample_push,
  input  tag_t         tag_in,
  input  logic         tag_push,
  input  logic         drain_en,
  input  logic         err_clear,
  output frame_t       frame,
  output logic         frame_valid,
  output fifo_status_t sample_status,
  output fifo_status_t tag_status,
  output err_count_t   sample_errors,
  output err_count_t   tag_errors
);

  sample_t sample_head;  // show-ahead heads
  tag_t    tag_head;
  logic    pop;          // joint pop from the packer
  logic    sample_err;   // reject pulses
  logic    tag_err;

  // sample channel
  fifo #(
    .payload_t  (sample_t),
    .DEPTH_LOG2 (`CAP_DEPTH_LOG2)
  ) sample_fifo_i (
    .clk      (clk),
    .reset_n  (reset_n),
    .data_in  (sample_in),
    .push     (sample_push),
    .pop      (pop),
    .data_out (sample_head),
    .status   (sample_status),
    .error    (sample_err)
  );

  // tag channel, same fifo on the narrow word
  fifo #(
    .payload_t  (tag_t),
    .DEPTH_LOG2 (`CAP_DEPTH_LOG2)
  ) tag_fifo_i (
    .clk      (clk),
    .reset_n  (reset_n),
    .data_in  (tag_in),
    .push     (tag_push),
    .pop      (pop),
    .data_out (tag_head),
    .status   (tag_status),
    .error    (tag_err)
  );

  frame_packer packer_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .drain_en      (drain_en),
    .sample_head   (sample_head),
    .tag_head      (tag_head),
    .sample_status (sample_status),
    .tag_status    (tag_status),
    .pop           (pop),
    .frame         (frame),
    .frame_valid   (frame_valid)
  );

  error_log err_log_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .err_clear     (err_clear),
    .sample_err    (sample_err),
    .tag_err       (tag_err),
    .sample_errors (sample_errors),
    .tag_errors    (tag_errors)
  );

endmodule : cap_top

//--- hw/error_log.sv
// ----------------------------------------------------------
// error log
// saturating per-channel counts of rejected pushes
// synchronous clear, clear beats a coincident error
// ----------------------------------------------------------
`timescale 1ns/1ps

module error_log
  import cap_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       err_clear,
  input  logic       sample_err,
  input  logic       tag_err,
  output err_count_t sample_errors,
  output err_count_t tag_errors
);

  // next value of one counter
  function automatic err_count_t next_count(
    input err_count_t cur,
    input logic       err,
    input logic       clear
  );
    err_count_t nxt;
    nxt = cur;
    if (clear)
    begin
      nxt = '0;  // clear has priority
    end
    else if (err && (cur != '1))
    begin
      nxt = cur + 1'b1;  // holds at all ones
    end
    return nxt;
  endfunction

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      sample_errors <= '0;
      tag_errors    <= '0;
    end
    else
    begin
      sample_errors <= next_count(sample_errors, sample_err, err_clear);
      tag_errors    <= next_count(tag_errors, tag_err, err_clear);
    end
  end

endmodule : error_log

//--- hw/frame_packer.sv
// ----------------------------------------------------------
// frame packer
// joint pop of sample and tag fifos, one registered frame
// with a one-cycle valid pulse per pop
// ----------------------------------------------------------
`timescale 1ns/1ps

module frame_packer
  import cap_pkg::*;
(
  input  logic         clk,
  input  logic         reset_n,
  input  logic         drain_en,
  input  sample_t      sample_head,
  input  tag_t         tag_head,
  input  fifo_status_t sample_status,
  input  fifo_status_t tag_status,
  output logic         pop,
  output frame_t       frame,
  output logic         frame_valid
);

  logic both_ready;  // each fifo has a head word

  assign both_ready = !sample_status.empty && !tag_status.empty;

  // single strobe drives both fifos, so they stay in lockstep
  assign pop = drain_en && both_ready;

  // valid pulse follows each pop by one cycle
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      frame_valid <= 1'b0;
    end
    else
    begin
      frame_valid <= pop;
    end
  end

  // capture the show-ahead heads at the popping edge
  always_ff @(posedge clk)
  begin
    if (pop)
    begin
      frame.tag    <= tag_head;
      frame.sample <= sample_head;
    end
  end

endmodule : frame_packer

//--- tb.f
+incdir+common
common/cap_pkg.sv
fifo/fifo.sv
hw/frame_packer.sv
hw/error_log.sv
hw/cap_top.sv
tb/tb_cap_top.sv

//--- tb/tb_cap_top.sv
// ----------------------------------------------------------
// capture buffer testbench
// clock, reset, lfsr data, queue model, compare tasks
// directed tests on flags, overflow, draining, error log
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "cap_defs.svh"

module tb_cap_top
  import cap_pkg::*;
();

  localparam int CAPACITY = (1 << `CAP_DEPTH_LOG2) - 1;  // one slot never used
  localparam int WAIT_LIMIT = 64;  // cycles per wait loop

  logic         clk;
  logic         reset_n;
  sample_t      sample_in;
  logic         sample_push;
  tag_t         tag_in;
  logic         tag_push;
  logic         drain_en;
  logic         err_clear;
  frame_t       frame;
  logic         frame_valid;
  fifo_status_t sample_status;
  fifo_status_t tag_status;
  err_count_t   sample_errors;
  err_count_t   tag_errors;

  sample_t    sample_q[$];  // model of fifo contents
  tag_t       tag_q[$];
  frame_t     frame_q[$];   // popped with frame pulse still due
  err_count_t exp_sample_err;
  err_count_t exp_tag_err;
  logic [15:0] lfsr;
  int errors;
  int checks;
  int frames_seen;

  cap_top dut_i (.*);

  always #4 clk = ~clk;  // 8 ns period

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // galois with taps 16 14 13 11
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[14:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // flags expected for a fill count
  function automatic fifo_status_t fill_status(input int count);
    fifo_status_t s;
    s.empty        = (count == 0);
    s.almost_empty = (count <= `CAP_ALMOST_EMPTY);
    s.almost_full  = (count >= `CAP_ALMOST_FULL);
    s.full         = (count == CAPACITY);
    return s;
  endfunction

  function automatic err_count_t count_after(input err_count_t cur, input logic rej,
                                             input logic clr);
    if (clr)
      return '0;  // clear beats a reject
    if (rej && (cur != '1))
      return cur + 1'b1;
    return cur;
  endfunction

  task automatic check_frame(input frame_t got, input frame_t exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %0t ns: %s frame %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_status(input fifo_status_t got, input fifo_status_t exp,
                              input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %0t ns: %s status %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input err_count_t got, input err_count_t exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %0t ns: %s count %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // drive one cycle at the falling edge and step the model
  task automatic drive_cycle(input logic drain, input logic sp, input sample_t sv,
                             input logic tp, input tag_t tv, input logic clr);
    logic   pop_exp;
    logic   s_ok;
    logic   t_ok;
    frame_t f;
    @(negedge clk);
    drain_en    = drain;
    sample_push = sp;
    sample_in   = sv;
    tag_push    = tp;
    tag_in      = tv;
    err_clear   = clr;
    pop_exp = drain && (sample_q.size() > 0) && (tag_q.size() > 0);
    s_ok = sp && ((sample_q.size() < CAPACITY) || pop_exp);  // full takes a push only with pop
    t_ok = tp && ((tag_q.size() < CAPACITY) || pop_exp);
    if (pop_exp)
    begin
      f.tag    = tag_q.pop_front();
      f.sample = sample_q.pop_front();
      frame_q.push_back(f);
    end
    if (s_ok)
      sample_q.push_back(sv);
    if (t_ok)
      tag_q.push_back(tv);
    exp_sample_err = count_after(exp_sample_err, sp && !s_ok, clr);
    exp_tag_err    = count_after(exp_tag_err, tp && !t_ok, clr);
  endtask

  task automatic idle(input int n);
    repeat (n) drive_cycle(drain_en, 1'b0, '0, 1'b0, '0, 1'b0);  // drain level kept
  endtask

  task automatic wait_frames(input int target, input string what);
    int n;
    n = 0;
    while ((frames_seen < target) && (n < WAIT_LIMIT))
    begin
      idle(1);
      n++;
    end
    if (frames_seen < target)
    begin
      errors++;
      $display("timeout after %0d cycles waiting for frames in %s", n, what);
    end
  endtask

  task automatic check_frame_total(input int exp, input string what);
    checks++;
    if ((frames_seen != exp) || (frame_q.size() != 0))
    begin
      errors++;
      $display("[FAIL] %0t ns: %s saw %0d frames, expected %0d", $time, what, frames_seen, exp);
    end
  endtask

  // every frame pulse is matched against the oldest model pop
  always @(negedge clk)
  begin
    if (reset_n && frame_valid)
    begin
      frames_seen++;
      if (frame_q.size() == 0)
      begin
        errors++;
        $display("frame_valid pulsed at %0t ns with no frame outstanding", $time);
      end
      else
        check_frame(frame, frame_q.pop_front(), "drain");
    end
  end

  task automatic reset_state();
    idle(4);  // any pulse here has nothing to match
    check_status(sample_status, fill_status(0), "reset sample");
    check_status(tag_status, fill_status(0), "reset tag");
    check_count(sample_errors, '0, "reset sample");
    check_count(tag_errors, '0, "reset tag");
    check_frame_total(0, "reset");
  endtask

  task automatic fill_flags();
    logic [15:0] v;
    for (int i = 0; i < CAPACITY; i++)
    begin
      draw_bits(16, v);
      drive_cycle(1'b0, 1'b1, v, 1'b0, '0, 1'b0);
      check_status(sample_status, fill_status(i), "fill");  // state before this push
    end
    idle(1);
    check_status(sample_status, fill_status(CAPACITY), "fill");
  endtask

  task automatic overflow_drop();
    logic [15:0] v;
    repeat (3)
    begin
      draw_bits(16, v);
      drive_cycle(1'b0, 1'b1, v, 1'b0, '0, 1'b0);  // dropped while fifo full
    end
    idle(1);
    check_count(sample_errors, 8'd3, "overflow");
    check_count(sample_errors, exp_sample_err, "overflow model");
    check_status(sample_status, fill_status(CAPACITY), "overflow");
  endtask

  task automatic ordered_drain();
    logic [15:0] v;
    int start;
    for (int i = 0; i < CAPACITY; i++)
    begin
      draw_bits(8, v);
      drive_cycle(1'b0, 1'b0, '0, 1'b1, v[7:0], 1'b0);
    end
    start = frames_seen;
    drive_cycle(1'b1, 1'b0, '0, 1'b0, '0, 1'b0);
    wait_frames(start + CAPACITY, "ordered drain");
    idle(3);
    check_frame_total(start + CAPACITY, "ordered drain");
    check_status(sample_status, fill_status(0), "drained sample");
    check_status(tag_status, fill_status(0), "drained tag");
    drive_cycle(1'b0, 1'b0, '0, 1'b0, '0, 1'b0);
  endtask

  task automatic push_full_with_pop();
    logic [15:0] v;
    logic [15:0] t;
    int start;
    for (int i = 0; i < CAPACITY; i++)
    begin
      draw_bits(16, v);
      draw_bits(8, t);
      drive_cycle(1'b0, 1'b1, v, 1'b1, t[7:0], 1'b0);
    end
    start = frames_seen;
    draw_bits(16, v);
    draw_bits(8, t);
    drive_cycle(1'b1, 1'b1, v, 1'b1, t[7:0], 1'b0);  // push into full as the packer pops
    check_status(sample_status, fill_status(CAPACITY), "full before pop");
    wait_frames(start + CAPACITY + 1, "push with pop");
    idle(3);
    check_frame_total(start + CAPACITY + 1, "push with pop");
    check_count(sample_errors, 8'd3, "push with pop");
    check_count(tag_errors, '0, "push with pop");
    drive_cycle(1'b0, 1'b0, '0, 1'b0, '0, 1'b0);
  endtask

  task automatic saturate_and_clear();
    logic [15:0] t;
    for (int i = 0; i < CAPACITY + 260; i++)
    begin
      draw_bits(8, t);
      drive_cycle(1'b0, 1'b0, '0, 1'b1, t[7:0], 1'b0);
    end
    idle(1);
    check_count(tag_errors, '1, "saturate");
    check_status(tag_status, fill_status(CAPACITY), "saturate tag");  // sample side is empty
    drive_cycle(1'b0, 1'b0, '0, 1'b1, 8'h5a, 1'b0);  // one more reject holds at max
    idle(1);
    check_count(tag_errors, '1, "hold at max");
    drive_cycle(1'b0, 1'b0, '0, 1'b1, 8'ha5, 1'b1);  // reject and clear together
    idle(1);
    check_count(sample_errors, '0, "clear sample");
    check_count(tag_errors, '0, "clear tag");
    check_count(tag_errors, exp_tag_err, "clear model");
  endtask

  initial
  begin
    clk         = 1'b0;
    reset_n     = 1'b0;
    sample_in   = '0;
    sample_push = 1'b0;
    tag_in      = '0;
    tag_push    = 1'b0;
    drain_en    = 1'b0;
    err_clear   = 1'b0;
    lfsr        = 16'd49366;
    errors      = 0;
    checks      = 0;
    frames_seen = 0;
    exp_sample_err = '0;
    exp_tag_err    = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    reset_state();
    fill_flags();
    overflow_drop();
    ordered_drain();
    push_full_with_pop();
    saturate_and_clear();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule : tb_cap_top
